// File: compile.f
noc_router_pkg.sv
router_input_fifo.sv
router_input_port.sv
router_arbiter.sv
router_lookahead_route.sv
router_output_port.sv
mesh_router.sv
tb_mesh_router.sv

// File: mesh_router.sv
// five-port mesh wormhole router
module mesh_router #(
  parameter int FifoDepth = 4
) (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  noc_router_pkg::xy_t                                  position_i,
  input  noc_router_pkg::flit_t [noc_router_pkg::NumPorts-1:0] data_i,
  input  noc_router_pkg::route_t                               data_void_i,
  input  noc_router_pkg::route_t                               stop_i,
  output noc_router_pkg::route_t                               stop_o,
  output noc_router_pkg::flit_t [noc_router_pkg::NumPorts-1:0] data_o,
  output noc_router_pkg::route_t                               data_void_o
);
  import noc_router_pkg::*;

  flit_t  [NumPorts-1:0] heads;
  route_t [NumPorts-1:0] reqs;
  // rd_all[o] names the input that output o reads
  route_t [NumPorts-1:0] rd_all;
  route_t                empties, rd_in;

  // an input is read when any output reads it
  always_comb begin
    rd_in = '0;
    for (int o = 0; o < NumPorts; o++) begin
      rd_in = rd_in | rd_all[o];
    end
  end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    router_input_port #(
      .FifoDepth(FifoDepth)
    ) input_port_inst (
      .clk        (clk),
      .rst        (rst),
      .data_i     (data_i[p]),
      .data_void_i(data_void_i[p]),
      .rd_i       (rd_in[p]),
      .stop_o     (stop_o[p]),
      .head_o     (heads[p]),
      .empty_o    (empties[p]),
      .req_o      (reqs[p])
    );

    router_output_port #(
      .OutPort(port_e'(p))
    ) output_port_inst (
      .clk        (clk),
      .rst        (rst),
      .position_i (position_i),
      .heads_i    (heads),
      .empties_i  (empties),
      .reqs_i     (reqs),
      .stop_i     (stop_i[p]),
      .rd_o       (rd_all[p]),
      .data_o     (data_o[p]),
      .data_void_o(data_void_o[p])
    );
  end

endmodule

// File: noc_router_pkg.sv
// mesh router shared types
package noc_router_pkg;

  // port order is also the bit order of every route_t
  typedef enum logic [2:0] {
    port_north = 3'd0,
    port_south = 3'd1,
    port_west  = 3'd2,
    port_east  = 3'd3,
    port_local = 3'd4
  } port_e;

  localparam int NumPorts = 5;
  // up to an 8x8 mesh
  localparam int CoordWidth = 3;
  localparam int FlitWidth = 34;

  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } xy_t;

  // one-hot output request, indexed by port_e
  typedef logic [NumPorts-1:0] route_t;

  typedef struct packed {
    logic head;
    logic tail;
  } preamble_t;

  typedef struct packed {
    preamble_t       preamble;
    xy_t             source;
    xy_t             destination;
    logic [3:0]      message;
    logic [10:0]     reserved;
    route_t          route;
  } header_t;

  typedef union packed {
    header_t              header;
    logic [FlitWidth-1:0] raw;
  } flit_t;

  // coordinate of the neighbour one hop along dir
  function automatic xy_t dir_step(xy_t pos, port_e dir);
    xy_t nxt;
    nxt = pos;
    case (dir)
      port_north: nxt.y = pos.y - 1'b1;
      port_south: nxt.y = pos.y + 1'b1;
      port_west:  nxt.x = pos.x - 1'b1;
      port_east:  nxt.x = pos.x + 1'b1;
      default:    nxt = pos;
    endcase
    return nxt;
  endfunction

endpackage

// File: router_arbiter.sv
// round-robin arbiter with worm lock
module router_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  input  noc_router_pkg::route_t req_i,
  input  logic                   head_fwd_i,
  input  logic                   tail_fwd_i,
  output noc_router_pkg::route_t grant_o
);
  import noc_router_pkg::*;

  route_t     rr_grant, lock_q;
  logic       locked_q;
  logic [2:0] ptr_q, grant_idx;

  // lowest offset from the pointer wins, so scan down and let it overwrite
  always_comb begin
    rr_grant = '0;
    for (int i = NumPorts - 1; i >= 0; i--) begin
      if (req_i[(ptr_q + i) % NumPorts]) begin
        rr_grant = '0;
        rr_grant[(ptr_q + i) % NumPorts] = 1'b1;
      end
    end
  end

  assign grant_o = locked_q ? lock_q : rr_grant;

  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < NumPorts; i++) begin
      if (grant_o[i]) grant_idx = 3'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      locked_q <= 1'b0;
      lock_q   <= '0;
      ptr_q    <= '0;
    end else if (tail_fwd_i) begin
      // worm done, priority moves past the winner
      locked_q <= 1'b0;
      ptr_q    <= (grant_idx == 3'(NumPorts - 1)) ? '0 : grant_idx + 1'b1;
    end else if (head_fwd_i) begin
      locked_q <= 1'b1;
      lock_q   <= grant_o;
    end
  end

endmodule

// File: router_input_fifo.sv
// input flit queue with bypass
module router_input_fifo #(
  parameter int FifoDepth = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr_i,
  input  noc_router_pkg::flit_t data_i,
  input  logic                  rd_i,
  output noc_router_pkg::flit_t head_o,
  output logic                  empty_o,
  output logic                  full_o
);
  import noc_router_pkg::*;

  localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CountWidth = $clog2(FifoDepth + 1);

  flit_t                 mem [FifoDepth];
  logic [PtrWidth-1:0]   rd_ptr_q, wr_ptr_q;
  logic [CountWidth-1:0] count_q;
  logic                  stored_empty, bypass, do_wr, do_rd;

  assign stored_empty = (count_q == '0);
  assign full_o  = (count_q == CountWidth'(FifoDepth));
  // an incoming flit is visible at once when nothing is queued
  assign head_o  = stored_empty ? data_i : mem[rd_ptr_q];
  assign empty_o = stored_empty & ~wr_i;

  // read of the bypassed flit consumes it without storing
  assign bypass = stored_empty & wr_i & rd_i;
  assign do_wr  = wr_i & ~full_o & ~bypass;
  assign do_rd  = rd_i & ~stored_empty;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CountWidth'(do_wr) - CountWidth'(do_rd);
    end
  end

endmodule

// File: router_input_port.sv
// router input port
module router_input_port #(
  parameter int FifoDepth = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  noc_router_pkg::flit_t  data_i,
  input  logic                   data_void_i,
  input  logic                   rd_i,
  output logic                   stop_o,
  output noc_router_pkg::flit_t  head_o,
  output logic                   empty_o,
  output noc_router_pkg::route_t req_o
);
  import noc_router_pkg::*;

  route_t req_q;
  logic   full, head_valid, tail_rd;

  router_input_fifo #(
    .FifoDepth(FifoDepth)
  ) fifo_inst (
    .clk    (clk),
    .rst    (rst),
    .wr_i   (~data_void_i),
    .data_i (data_i),
    .rd_i   (rd_i),
    .head_o (head_o),
    .empty_o(empty_o),
    .full_o (full)
  );

  assign stop_o     = full;
  assign head_valid = ~empty_o & head_o.header.preamble.head;
  assign tail_rd    = rd_i & ~empty_o & head_o.header.preamble.tail;

  // hold the worm's request from its head until the tail leaves
  always_ff @(posedge clk) begin
    if (rst) begin
      req_q <= '0;
    end else if (tail_rd) begin
      req_q <= '0;
    end else if (head_valid) begin
      req_q <= head_o.header.route;
    end
  end

  assign req_o = empty_o ? '0 : (head_valid ? head_o.header.route : req_q);

endmodule

// File: router_lookahead_route.sv
// XY route for the next router
module router_lookahead_route #(
  parameter noc_router_pkg::port_e OutPort = noc_router_pkg::port_local
) (
  input  noc_router_pkg::xy_t    position_i,
  input  noc_router_pkg::xy_t    dest_i,
  output noc_router_pkg::route_t next_route_o
);
  import noc_router_pkg::*;

  xy_t next_pos;

  assign next_pos = dir_step(position_i, OutPort);

  // x first, then y, local when both match
  always_comb begin
    next_route_o = '0;
    if (OutPort != port_local) begin
      if (dest_i.x > next_pos.x) begin
        next_route_o[port_east] = 1'b1;
      end else if (dest_i.x < next_pos.x) begin
        next_route_o[port_west] = 1'b1;
      end else if (dest_i.y > next_pos.y) begin
        next_route_o[port_south] = 1'b1;
      end else if (dest_i.y < next_pos.y) begin
        next_route_o[port_north] = 1'b1;
      end else begin
        next_route_o[port_local] = 1'b1;
      end
    end
  end

endmodule

// File: router_output_port.sv
// router output port
module router_output_port #(
  parameter noc_router_pkg::port_e OutPort = noc_router_pkg::port_local
) (
  input  logic                                               clk,
  input  logic                                               rst,
  input  noc_router_pkg::xy_t                                position_i,
  input  noc_router_pkg::flit_t  [noc_router_pkg::NumPorts-1:0] heads_i,
  input  noc_router_pkg::route_t                             empties_i,
  input  noc_router_pkg::route_t [noc_router_pkg::NumPorts-1:0] reqs_i,
  input  logic                                               stop_i,
  output noc_router_pkg::route_t                             rd_o,
  output noc_router_pkg::flit_t                              data_o,
  output logic                                               data_void_o
);
  import noc_router_pkg::*;

  typedef enum logic {
    st_reserve,
    st_forward
  } state_e;

  state_e state_q, state_d;
  route_t req_mask, grant, next_route;
  flit_t  sel_flit, out_flit;
  logic   sel_valid, fwd, head_fwd, tail_fwd;

  ////////////////////////////////////////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////////////////////////////////////////

  // an input never turns back onto its own port
  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      req_mask[i] = reqs_i[i][OutPort] & ~empties_i[i] & (i != int'(OutPort));
    end
  end

  router_arbiter arbiter_inst (
    .clk       (clk),
    .rst       (rst),
    .req_i     (req_mask),
    .head_fwd_i(head_fwd),
    .tail_fwd_i(tail_fwd),
    .grant_o   (grant)
  );

  ////////////////////////////////////////////////////////////////////////////
  // input select and look-ahead
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sel_flit  = '0;
    sel_valid = 1'b0;
    for (int i = 0; i < NumPorts; i++) begin
      if (grant[i]) begin
        sel_flit  = heads_i[i];
        sel_valid = ~empties_i[i];
      end
    end
  end

  router_lookahead_route #(
    .OutPort(OutPort)
  ) lookahead_inst (
    .position_i  (position_i),
    .dest_i      (sel_flit.header.destination),
    .next_route_o(next_route)
  );

  // only a worm's first flit is taken in the reserve state
  always_comb begin
    out_flit = sel_flit;
    if (state_q == st_reserve) begin
      out_flit.header.route = next_route;
    end
  end

  assign fwd      = ~stop_i & sel_valid;
  assign head_fwd = fwd & sel_flit.header.preamble.head;
  assign tail_fwd = fwd & sel_flit.header.preamble.tail;
  assign rd_o     = grant & {NumPorts{fwd}};

  ////////////////////////////////////////////////////////////////////////////
  // reservation FSM and output register
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_reserve: if (fwd && !tail_fwd) state_d = st_forward;
      st_forward: if (tail_fwd) state_d = st_reserve;
      default:    state_d = st_reserve;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= st_reserve;
      data_void_o <= 1'b1;
    end else begin
      state_q <= state_d;
      // hold the link while the neighbour stalls
      if (!stop_i) data_void_o <= ~fwd;
    end
  end

  always_ff @(posedge clk) begin
    if (fwd) begin
      data_o <= out_flit;
    end
  end

endmodule

// File: tb_mesh_router.sv
// mesh router testbench
module tb_mesh_router;
  timeunit 1ns;
  timeprecision 1ps;
  import noc_router_pkg::*;

  localparam int FifoDepth = 4;
  localparam int ResetCycles = 16;
  localparam int North = 0;
  localparam int South = 1;
  localparam int West = 2;
  localparam int East = 3;
  localparam int Local = 4;
  // every flit of every worm sent below
  localparam int TotalFlits = 5 * 4 + 3 * 6 + 10 + 3 * 5 + 4;
  localparam int WatchdogCycles = 200 * TotalFlits;

  logic                  clk;
  logic                  rst;
  xy_t                   position;
  flit_t [NumPorts-1:0]  data_in;
  flit_t [NumPorts-1:0]  data_out;
  route_t                void_in, stop_in, stop_out, void_out;

  // expected flits, indexed by output * NumPorts + input
  flit_t       exp_q [NumPorts*NumPorts][$];
  int          cur_src [NumPorts];
  int          sent_cnt [NumPorts];
  int          errors, tests, tests_failed;
  logic [31:0] rng_state;

  mesh_router #(
    .FifoDepth(FifoDepth)
  ) mesh_router_inst (
    .clk        (clk),
    .rst        (rst),
    .position_i (position),
    .data_i     (data_in),
    .data_void_i(void_in),
    .stop_i     (stop_in),
    .stop_o     (stop_out),
    .data_o     (data_out),
    .data_void_o(void_out)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] next_random();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[30:15];
  endfunction

  // neighbour one hop along an output, north is y-1
  function automatic xy_t step_to(xy_t at, int dir);
    xy_t nb;
    nb = at;
    case (dir)
      North: nb.y = at.y - 3'd1;
      South: nb.y = at.y + 3'd1;
      West:  nb.x = at.x - 3'd1;
      East:  nb.x = at.x + 3'd1;
      default: nb = at;
    endcase
    return nb;
  endfunction

  function automatic route_t xy_request(xy_t at, xy_t dest);
    route_t r;
    r = '0;
    if (dest.x > at.x) r[East] = 1'b1;
    else if (dest.x < at.x) r[West] = 1'b1;
    else if (dest.y > at.y) r[South] = 1'b1;
    else if (dest.y < at.y) r[North] = 1'b1;
    else r[Local] = 1'b1;
    return r;
  endfunction

  function automatic int port_of(route_t r);
    int p;
    p = 0;
    for (int i = 0; i < NumPorts; i++) begin
      if (r[i]) p = i;
    end
    return p;
  endfunction

  // no destination may send a worm back out of its own input
  function automatic xy_t random_dest(int in_p);
    xy_t d;
    do begin
      d = 6'(next_random());
    end while (port_of(xy_request(position, d)) == in_p);
    return d;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int i = 0; i < NumPorts * NumPorts; i++) begin
      n += exp_q[i].size();
    end
    return n;
  endfunction

  task automatic log_error(string msg);
    $display("ERR %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic end_test(string name, int mark);
    tests++;
    if (errors == mark) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - mark);
    end
  endtask

  task automatic wait_drained();
    while (pending() != 0) @(negedge clk);
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and output monitor
  ////////////////////////////////////////////////////////////////////////////

  // the message field tags the input so the monitor finds the worm
  task automatic send_worm(int in_p, xy_t dest, int n_payload);
    flit_t  worm [$];
    flit_t  f;
    route_t first_hop;
    int     out_p;
    first_hop = xy_request(position, dest);
    out_p = port_of(first_hop);
    f = '0;
    f.header.preamble.head = 1'b1;
    f.header.source = 6'(next_random());
    f.header.destination = dest;
    f.header.message = 4'(in_p);
    f.header.reserved = 11'(next_random());
    f.header.route = first_hop;
    worm.push_back(f);
    for (int i = 0; i < n_payload; i++) begin
      f.raw = {1'b0, i == n_payload - 1, next_random(), next_random()};
      worm.push_back(f);
    end
    foreach (worm[i]) begin
      f = worm[i];
      if (i == 0) begin
        f.header.route = (out_p == Local) ? '0 : xy_request(step_to(position, out_p), dest);
      end
      exp_q[out_p*NumPorts+in_p].push_back(f);
    end
    foreach (worm[i]) begin
      @(negedge clk);
      data_in[in_p] = worm[i];
      void_in[in_p] = 1'b0;
      while (stop_out[in_p]) @(negedge clk);
      @(posedge clk);
      sent_cnt[in_p]++;
    end
    @(negedge clk);
    void_in[in_p] = 1'b1;
  endtask

  task automatic check_output(int o, flit_t f);
    flit_t want;
    int    src;
    if (cur_src[o] < 0) begin
      src = int'(f.header.message);
      assert (f.header.preamble.head)
        else log_error($sformatf("flit %h on output %0d outside a worm", f, o));
    end else begin
      src = cur_src[o];
    end
    if (src >= NumPorts || exp_q[o*NumPorts+src].size() == 0) begin
      log_error($sformatf("unexpected flit %h on output %0d", f, o));
      return;
    end
    want = exp_q[o*NumPorts+src].pop_front();
    assert (f == want)
      else log_error($sformatf("output %0d got %h, expected %h", o, f, want));
    cur_src[o] = want.header.preamble.tail ? -1 : src;
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      for (int o = 0; o < NumPorts; o++) begin
        if (!void_out[o] && !stop_in[o]) check_output(o, data_out[o]);
      end
    end
  end

  initial begin
    repeat (ResetCycles + WatchdogCycles) @(posedge clk);
    $display("timeout: run still going after %0d cycles, %0d flits undelivered",
             WatchdogCycles, pending());
    $display("Regression failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int    mark, base;
    flit_t held;
    logic  held_void;
    rng_state = 32'd93997;
    errors = 0;
    tests = 0;
    tests_failed = 0;
    rst = 1'b1;
    position = {3'd3, 3'd3};
    data_in = '0;
    void_in = '1;
    stop_in = '0;
    for (int p = 0; p < NumPorts; p++) begin
      cur_src[p] = -1;
      sent_cnt[p] = 0;
    end
    repeat (ResetCycles) @(negedge clk);
    rst = 1'b0;

    mark = errors;
    repeat (5) begin
      @(negedge clk);
      assert (void_out == '1 && stop_out == '0)
        else log_error("links not idle after reset");
    end
    end_test("reset", mark);

    mark = errors;
    for (int p = 0; p < NumPorts; p++) begin
      send_worm(p, random_dest(p), 3);
      wait_drained();
    end
    end_test("single worms", mark);

    // three inputs compete for the local output
    mark = errors;
    fork
      send_worm(West, position, 5);
      send_worm(East, position, 5);
      send_worm(North, position, 5);
    join
    wait_drained();
    end_test("contention", mark);

    mark = errors;
    fork
      send_worm(West, {3'd6, 3'd2}, 9);
      begin
        @(negedge clk);
        while (void_out[East]) @(negedge clk);
        stop_in[East] = 1'b1;
        held = data_out[East];
        held_void = void_out[East];
        base = sent_cnt[West];
        while (!stop_out[West]) begin
          @(negedge clk);
          assert (data_out[East] == held && void_out[East] == held_void)
            else log_error("east output changed while stopped");
        end
        assert (sent_cnt[West] - base == FifoDepth)
          else log_error($sformatf("west stop after %0d flits", sent_cnt[West] - base));
        repeat (8) begin
          @(negedge clk);
          assert (data_out[East] == held && void_out[East] == held_void)
            else log_error("east output changed while stopped");
        end
        stop_in[East] = 1'b0;
      end
    join
    wait_drained();
    end_test("back-pressure", mark);

    // a worm waits on the stopped south output while the others drain
    mark = errors;
    stop_in[North] = 1'b1;
    stop_in[South] = 1'b1;
    fork
      send_worm(West, {3'd5, 3'd1}, 4);
      send_worm(East, {3'd0, 3'd4}, 4);
      send_worm(South, position, 4);
      send_worm(North, {3'd3, 3'd6}, 3);
    join
    while (pending() != exp_q[South*NumPorts+North].size()) @(negedge clk);
    stop_in = '0;
    wait_drained();
    end_test("parallel outputs", mark);

    $display("%0d tests, %0d failed, %0d errors", tests, tests_failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
